// File: design/pack_pkg.sv
/*
 * frame packer package
 * sizes, word formats and superpacket descriptor and metadata records
 */

package pack_pkg;

    // channel and word geometry
    localparam int CHANNELS   = 4;
    localparam int CH_W       = 2;
    localparam int DATA_W     = 32;
    localparam int DROP_CNT_W = 16;

    // user packet limits
    localparam int PKT_WORDS_MAX = 8;
    localparam int LEN_W         = 4;

    // superpacket limits
    localparam int SPKT_WORDS_MAX = 16;
    localparam int SPKT_LEN_W     = 5;
    localparam logic [SPKT_LEN_W-1:0] SPKT_FULL = SPKT_LEN_W'(SPKT_WORDS_MAX);

    // per lane buffering
    localparam int LANE_DEPTH = 32;
    localparam int DESC_DEPTH = 4;

    // idle close of an open superpacket
    localparam int TIMEOUT_CLK = 24;
    localparam int TIMEOUT_W   = $clog2(TIMEOUT_CLK + 1);
    localparam logic [TIMEOUT_W-1:0] TIMEOUT_LAST = TIMEOUT_W'(TIMEOUT_CLK - 1);

    // one input beat, len only meaningful with sof
    typedef struct packed {
        logic              sof;
        logic              eof;
        logic [CH_W-1:0]   channel;
        logic [LEN_W-1:0]  len;
        logic [DATA_W-1:0] data;
    } in_word_t;

    // word as stored inside a lane
    typedef struct packed {
        logic              sof;
        logic              eof;
        logic [DATA_W-1:0] data;
    } lane_word_t;

    // one closed superpacket
    typedef struct packed {
        logic [SPKT_LEN_W-1:0] words;
        logic [SPKT_LEN_W-1:0] pkts;
    } spkt_desc_t;

    // metadata sent with the first output word
    typedef struct packed {
        logic [CH_W-1:0]       channel;
        logic [SPKT_LEN_W-1:0] words;
        logic [SPKT_LEN_W-1:0] pkts;
    } out_meta_t;

endpackage

// File: design/pack_fifo.sv
/*
 * show-ahead synchronous FIFO
 * generic payload type, reports the number of free entries
 */

`timescale 1ns/1ps

module pack_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         wr,
    input  payload_t                     wr_data,
    input  logic                         rd,
    output payload_t                     rd_data,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   free
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [AW-1:0] LAST_IDX  = AW'(DEPTH - 1);
    localparam logic [CW-1:0] FULL_FREE = CW'(DEPTH);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;

    // head entry is always visible
    assign rd_data = mem[rd_ptr];
    assign empty   = (free == FULL_FREE);

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            free   <= FULL_FREE;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   free <= free - 1'b1;
                2'b01:   free <= free + 1'b1;
                default: free <= free;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) wr |-> free != '0);
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) rd |-> !empty);

endmodule

// File: design/pack_dispatch.sv
/*
 * input dispatcher
 * checks declared packet lengths and routes each accepted packet to its lane
 */

`timescale 1ns/1ps

module pack_dispatch (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                in_vld,
    input  pack_pkg::in_word_t                  in_word,
    output logic [pack_pkg::CHANNELS-1:0]       lane_vld,
    output pack_pkg::lane_word_t                lane_word,
    output logic [pack_pkg::LEN_W-1:0]          lane_len,
    output logic [pack_pkg::DROP_CNT_W-1:0]     drop_cnt
);

    logic                      len_ok;
    logic                      acc_q;
    logic                      acc_now;
    logic [pack_pkg::CH_W-1:0] ch_q;
    logic [pack_pkg::CH_W-1:0] ch_now;
    logic                      in_pkt;
    logic [pack_pkg::CHANNELS-1:0] route;

    assign len_ok = (in_word.len != '0) && (int'(in_word.len) <= pack_pkg::PKT_WORDS_MAX);

    // sof decides, later beats follow the latched decision
    assign acc_now = in_word.sof ? len_ok : acc_q;
    assign ch_now  = in_word.sof ? in_word.channel : ch_q;

    always_comb begin
        route         = '0;
        route[ch_now] = in_vld && acc_now;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q    <= 1'b0;
            ch_q     <= '0;
            in_pkt   <= 1'b0;
            lane_vld <= '0;
            drop_cnt <= '0;
        end else begin
            lane_vld <= route;
            if (in_vld) begin
                acc_q  <= acc_now;
                ch_q   <= ch_now;
                in_pkt <= !in_word.eof;
            end
            if (in_vld && in_word.sof && !len_ok) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        lane_word <= '{sof: in_word.sof, eof: in_word.eof, data: in_word.data};
        lane_len  <= in_word.len;
    end

    a_no_nested_sof: assert property (@(posedge clk) disable iff (!arst_n)
        (in_vld && in_word.sof) |-> !in_pkt);

endmodule

// File: design/pack_lane.sv
/*
 * per channel packing lane
 * buffers words, closes superpackets by size or idle timeout, queues descriptors
 */

`timescale 1ns/1ps

module pack_lane (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           word_vld,
    input  pack_pkg::lane_word_t           word,
    input  logic [pack_pkg::LEN_W-1:0]     pkt_len,
    input  logic                           word_pop,
    output pack_pkg::lane_word_t           word_head,
    output logic                           desc_rdy,
    input  logic                           desc_pop,
    output pack_pkg::spkt_desc_t           desc_head,
    output logic                           lane_drop
);

    logic [$clog2(pack_pkg::LANE_DEPTH+1)-1:0] word_free;
    logic [$clog2(pack_pkg::DESC_DEPTH+1)-1:0] desc_free;
    logic                                      desc_empty;

    // open superpacket state
    logic [pack_pkg::SPKT_LEN_W-1:0] spkt_words;
    logic [pack_pkg::SPKT_LEN_W-1:0] spkt_pkts;
    logic [pack_pkg::TIMEOUT_W-1:0]  idle_cnt;
    logic                            in_pkt;
    logic                            drop_pkt;

    logic                            fits;
    logic                            wr_word;
    logic                            close_sof;
    logic                            close_eof;
    logic                            close_tmo;
    logic                            desc_wr;
    pack_pkg::spkt_desc_t            desc_wdata;
    logic [pack_pkg::SPKT_LEN_W-1:0] words_base;
    logic [pack_pkg::SPKT_LEN_W-1:0] pkts_base;
    logic [pack_pkg::SPKT_LEN_W-1:0] words_next;
    logic [pack_pkg::SPKT_LEN_W-1:0] pkts_next;

    // whole packet must fit at its sof
    assign fits    = int'(pkt_len) <= int'(word_free);
    assign wr_word = word_vld && (word.sof ? fits : !drop_pkt);

    // next packet would overflow the open superpacket
    assign close_sof = word_vld && word.sof && fits &&
                       (int'(spkt_words) + int'(pkt_len) > pack_pkg::SPKT_WORDS_MAX);

    assign words_base = close_sof ? '0 : spkt_words;
    assign pkts_base  = close_sof ? '0 : spkt_pkts;
    assign words_next = words_base + {{(pack_pkg::SPKT_LEN_W-1){1'b0}}, wr_word};
    assign pkts_next  = pkts_base + {{(pack_pkg::SPKT_LEN_W-1){1'b0}}, wr_word && word.eof};

    assign close_eof = wr_word && word.eof && (words_next == pack_pkg::SPKT_FULL);
    assign close_tmo = !word_vld && !in_pkt && (spkt_words != '0) &&
                       (idle_cnt == pack_pkg::TIMEOUT_LAST);

    assign desc_wr    = close_sof || close_eof || close_tmo;
    assign desc_wdata = close_eof ? '{words: pack_pkg::SPKT_FULL, pkts: pkts_next}
                                  : '{words: spkt_words, pkts: spkt_pkts};
    assign desc_rdy   = !desc_empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            spkt_words <= '0;
            spkt_pkts  <= '0;
            idle_cnt   <= '0;
            in_pkt     <= 1'b0;
            drop_pkt   <= 1'b0;
            lane_drop  <= 1'b0;
        end else begin
            lane_drop <= word_vld && word.sof && !fits;
            if (word_vld) begin
                in_pkt <= !word.eof;
                if (word.sof) begin
                    drop_pkt <= !fits;
                end
            end
            if (close_eof || close_tmo) begin
                spkt_words <= '0;
                spkt_pkts  <= '0;
            end else begin
                spkt_words <= words_next;
                spkt_pkts  <= pkts_next;
            end
            // timer only runs between packets with something open
            if (word_vld || close_tmo || in_pkt || spkt_words == '0) begin
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    pack_fifo #(
        .payload_t (pack_pkg::lane_word_t),
        .DEPTH     (pack_pkg::LANE_DEPTH)
    ) word_fifo (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr      (wr_word),
        .wr_data (word),
        .rd      (word_pop),
        .rd_data (word_head),
        .empty   (),
        .free    (word_free)
    );

    pack_fifo #(
        .payload_t (pack_pkg::spkt_desc_t),
        .DEPTH     (pack_pkg::DESC_DEPTH)
    ) desc_fifo (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr      (desc_wr),
        .wr_data (desc_wdata),
        .rd      (desc_pop),
        .rd_data (desc_head),
        .empty   (desc_empty),
        .free    (desc_free)
    );

    a_desc_room: assert property (@(posedge clk) disable iff (!arst_n)
        desc_wr |-> desc_free != '0);

endmodule

// File: design/pack_drain.sv
/*
 * superpacket drain
 * round robin over ready lanes, sends one superpacket at a time with metadata
 */

`timescale 1ns/1ps

module pack_drain (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [pack_pkg::CHANNELS-1:0]     desc_rdy,
    input  pack_pkg::spkt_desc_t              desc_head [pack_pkg::CHANNELS],
    output logic [pack_pkg::CHANNELS-1:0]     desc_pop,
    output logic [pack_pkg::CHANNELS-1:0]     word_pop,
    input  pack_pkg::lane_word_t              word_head [pack_pkg::CHANNELS],
    output logic                              out_vld,
    output logic                              out_sof,
    output logic                              out_eof,
    output logic [pack_pkg::DATA_W-1:0]       out_data,
    output pack_pkg::out_meta_t               out_meta
);

    typedef enum logic {ST_IDLE, ST_SEND} state_t;

    state_t                          state;
    logic [pack_pkg::CH_W-1:0]       rr_ptr;
    logic [pack_pkg::CH_W-1:0]       cur_ch;
    logic [pack_pkg::CH_W-1:0]       pick;
    logic                            found;
    logic [pack_pkg::SPKT_LEN_W-1:0] remaining;
    logic                            first;
    pack_pkg::spkt_desc_t            desc_q;
    pack_pkg::lane_word_t            cur_word;

    // first ready lane at or after rr_ptr
    always_comb begin
        logic [pack_pkg::CH_W-1:0] idx;
        found = 1'b0;
        pick  = rr_ptr;
        for (int i = pack_pkg::CHANNELS - 1; i >= 0; i--) begin
            idx = rr_ptr + i[pack_pkg::CH_W-1:0];
            if (desc_rdy[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    always_comb begin
        desc_pop = '0;
        word_pop = '0;
        if (state == ST_IDLE) begin
            desc_pop[pick] = found;
        end else begin
            word_pop[cur_ch] = 1'b1;
        end
    end

    assign cur_word = word_head[cur_ch];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            rr_ptr    <= '0;
            cur_ch    <= '0;
            remaining <= '0;
            first     <= 1'b0;
            out_vld   <= 1'b0;
            out_sof   <= 1'b0;
            out_eof   <= 1'b0;
        end else begin
            out_vld <= (state == ST_SEND);
            out_sof <= (state == ST_SEND) && first;
            out_eof <= (state == ST_SEND) && (remaining == 1);
            if (state == ST_IDLE) begin
                if (found) begin
                    state     <= ST_SEND;
                    cur_ch    <= pick;
                    rr_ptr    <= pick + 1'b1;
                    remaining <= desc_head[pick].words;
                    first     <= 1'b1;
                end
            end else begin
                first     <= 1'b0;
                remaining <= remaining - 1'b1;
                if (remaining == 1) begin
                    state <= ST_IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && found) begin
            desc_q <= desc_head[pick];
        end
        if (state == ST_SEND) begin
            out_data <= cur_word.data;
        end
        if (state == ST_SEND && first) begin
            out_meta <= '{channel: cur_ch, words: desc_q.words, pkts: desc_q.pkts};
        end
    end

    // descriptor count and lane word framing must agree
    a_last_is_eof: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ST_SEND && remaining == 1) |-> cur_word.eof);

endmodule

// File: design/frame_packer.sv
/*
 * multi-channel frame packer top level
 * dispatcher, one packing lane per channel and a round robin drain
 */

`timescale 1ns/1ps

module frame_packer (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_vld,
    input  pack_pkg::in_word_t                in_word,
    output logic                              out_vld,
    output logic                              out_sof,
    output logic                              out_eof,
    output logic [pack_pkg::DATA_W-1:0]       out_data,
    output pack_pkg::out_meta_t               out_meta,
    output logic [pack_pkg::DROP_CNT_W-1:0]   drop_cnt
);

    logic [pack_pkg::CHANNELS-1:0]  lane_vld;
    pack_pkg::lane_word_t           lane_word;
    logic [pack_pkg::LEN_W-1:0]     lane_len;
    logic [pack_pkg::CHANNELS-1:0]  desc_rdy;
    logic [pack_pkg::CHANNELS-1:0]  desc_pop;
    logic [pack_pkg::CHANNELS-1:0]  word_pop;
    pack_pkg::spkt_desc_t           desc_head [pack_pkg::CHANNELS];
    pack_pkg::lane_word_t           word_head [pack_pkg::CHANNELS];

    pack_dispatch dispatch0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_vld    (in_vld),
        .in_word   (in_word),
        .lane_vld  (lane_vld),
        .lane_word (lane_word),
        .lane_len  (lane_len),
        .drop_cnt  (drop_cnt)
    );

    for (genvar g = 0; g < pack_pkg::CHANNELS; g++) begin : g_lane
        pack_lane lane (
            .clk       (clk),
            .arst_n    (arst_n),
            .word_vld  (lane_vld[g]),
            .word      (lane_word),
            .pkt_len   (lane_len),
            .word_pop  (word_pop[g]),
            .word_head (word_head[g]),
            .desc_rdy  (desc_rdy[g]),
            .desc_pop  (desc_pop[g]),
            .desc_head (desc_head[g]),
            .lane_drop ()
        );
    end

    pack_drain drain0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .desc_rdy  (desc_rdy),
        .desc_head (desc_head),
        .desc_pop  (desc_pop),
        .word_pop  (word_pop),
        .word_head (word_head),
        .out_vld   (out_vld),
        .out_sof   (out_sof),
        .out_eof   (out_eof),
        .out_data  (out_data),
        .out_meta  (out_meta)
    );

endmodule

// File: sim/tb_clock.sv
/*
 * testbench clock and reset source
 * free running clock, active low reset released on a falling edge
 */

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: sim/tb_frame_packer.sv
/*
 * frame packer testbench
 * xorshift stimulus, per channel reference model and output collector
 */

`timescale 1ns/1ps

module tb_frame_packer;

    localparam int GAP_TMO   = pack_pkg::TIMEOUT_CLK + 1;
    localparam int SETTLE    = 200;
    localparam int SIZE_PKTS = 16;
    localparam int RAND_PKTS = 160;
    localparam int BAD_PKTS  = 24;
    // upper bound on beats over all tests
    localparam int MAX_BEATS = (SIZE_PKTS + RAND_PKTS) * pack_pkg::PKT_WORDS_MAX + BAD_PKTS * 15 + 64;

    logic                              clk;
    logic                              arst_n;
    logic                              in_vld;
    pack_pkg::in_word_t                in_word;
    logic                              out_vld;
    logic                              out_sof;
    logic                              out_eof;
    logic [pack_pkg::DATA_W-1:0]       out_data;
    pack_pkg::out_meta_t               out_meta;
    logic [pack_pkg::DROP_CNT_W-1:0]   drop_cnt;

    int unsigned rng = 32'hfb7f_81a0;
    int          cyc = 0;
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    int          test_err0 = 0;

    // reference model state
    int                   open_words [pack_pkg::CHANNELS];
    int                   open_pkts [pack_pkg::CHANNELS];
    int                   last_beat [pack_pkg::CHANNELS];
    logic                 mid [pack_pkg::CHANNELS];
    logic                 cur_acc = 1'b0;
    int                   cur_ch = 0;
    int                   model_drops = 0;
    logic [31:0]          exp_data [pack_pkg::CHANNELS][$];
    pack_pkg::spkt_desc_t exp_desc [pack_pkg::CHANNELS][$];

    // collector state
    logic                 spkt_open = 1'b0;
    pack_pkg::out_meta_t  col_meta;
    int                   col_cnt = 0;
    int                   sof_cnt = 0;
    int                   sof_cyc = 0;
    int                   served [$];
    logic [31:0]          want_word;
    pack_pkg::spkt_desc_t want_desc;

    tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(2)) clock0 (.clk(clk), .arst_n(arst_n));

    frame_packer dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_vld   (in_vld),
        .in_word  (in_word),
        .out_vld  (out_vld),
        .out_sof  (out_sof),
        .out_eof  (out_eof),
        .out_data (out_data),
        .out_meta (out_meta),
        .drop_cnt (drop_cnt)
    );

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int unsigned xorshift(input int unsigned x);
        int unsigned y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned next_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic int pick_below(input int unsigned n);
        return int'(next_word() % n);
    endfunction

    task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] exp);
        $display("ERROR t=%0t %s: got %0h expected %0h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic note_error(input string what);
        $display("ERROR t=%0t: %s", $time, what);
        errors++;
    endtask

    task automatic close_open(input int ch);
        pack_pkg::spkt_desc_t d;
        d.words = pack_pkg::SPKT_LEN_W'(open_words[ch]);
        d.pkts  = pack_pkg::SPKT_LEN_W'(open_pkts[ch]);
        exp_desc[ch].push_back(d);
        open_words[ch] = 0;
        open_pkts[ch]  = 0;
    endtask

    // t is the input edge that samples this beat
    task automatic model_beat(input pack_pkg::in_word_t w, input int t);
        if (w.sof) begin
            cur_ch  = int'(w.channel);
            cur_acc = (w.len != '0) && (int'(w.len) <= pack_pkg::PKT_WORDS_MAX);
            if (!cur_acc) begin
                model_drops++;
            end else if (open_words[cur_ch] + int'(w.len) > pack_pkg::SPKT_WORDS_MAX) begin
                close_open(cur_ch);
            end
        end
        if (cur_acc) begin
            open_words[cur_ch]++;
            exp_data[cur_ch].push_back(w.data);
            last_beat[cur_ch] = t;
            mid[cur_ch] = !w.eof;
            if (w.eof) begin
                open_pkts[cur_ch]++;
                if (open_words[cur_ch] == pack_pkg::SPKT_WORDS_MAX) begin
                    close_open(cur_ch);
                end
            end
        end
    endtask

    task automatic drive_cycle(input logic vld, input pack_pkg::in_word_t w);
        int t;
        @(negedge clk);
        t = cyc + 1;
        // idle close counted from the last accepted beat
        for (int ch = 0; ch < pack_pkg::CHANNELS; ch++) begin
            if (open_words[ch] != 0 && !mid[ch] && t - last_beat[ch] >= GAP_TMO) begin
                close_open(ch);
            end
        end
        in_vld  = vld;
        in_word = w;
        if (vld) begin
            model_beat(w, t);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0);
    endtask

    function automatic logic output_pending();
        logic busy;
        busy = spkt_open;
        for (int ch = 0; ch < pack_pkg::CHANNELS; ch++) begin
            if (exp_data[ch].size() != 0 || exp_desc[ch].size() != 0) begin
                busy = 1'b1;
            end
        end
        return busy;
    endfunction

    // idle cycles until the model expects no more output
    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (output_pending() && n < limit) begin
            idle(1);
            n++;
        end
    endtask

    task automatic send_packet(input int ch, input int len, input int beats, input int gap);
        pack_pkg::in_word_t w;
        for (int i = 0; i < beats; i++) begin
            w.sof     = (i == 0);
            w.eof     = (i == beats - 1);
            w.channel = pack_pkg::CH_W'(ch);
            w.len     = pack_pkg::LEN_W'(len);
            w.data    = next_word();
            drive_cycle(1'b1, w);
            idle(gap);
        end
    endtask

    task automatic end_test(input string name);
        wait_drained(SETTLE);
        for (int ch = 0; ch < pack_pkg::CHANNELS; ch++) begin
            if (exp_data[ch].size() != 0) begin
                note_error($sformatf("channel %0d: %0d words never came out", ch,
                                     exp_data[ch].size()));
            end
            if (exp_desc[ch].size() != 0) begin
                note_error($sformatf("channel %0d: %0d superpackets never came out", ch,
                                     exp_desc[ch].size()));
            end
        end
        if (spkt_open) begin
            note_error("superpacket still open after the output went quiet");
        end
        if (drop_cnt !== pack_pkg::DROP_CNT_W'(model_drops)) begin
            value_error("drop_cnt", 32'(drop_cnt), 32'(model_drops));
        end
        tests++;
        if (errors != test_err0) begin
            failed++;
            $display("test %s: %0d errors", name, errors - test_err0);
        end else begin
            $display("test %s: ok", name);
        end
        test_err0 = errors;
    endtask

    // collects output superpackets and checks them against the model
    always @(negedge clk) begin
        if (arst_n && out_vld) begin
            if (out_sof) begin
                if (spkt_open) begin
                    note_error("out_sof arrived before the previous out_eof");
                end
                spkt_open = 1'b1;
                col_meta  = out_meta;
                col_cnt   = 0;
                sof_cnt++;
                sof_cyc   = cyc;
                served.push_back(int'(out_meta.channel));
            end
            if (!spkt_open) begin
                note_error("output word outside any superpacket");
            end else begin
                col_cnt++;
                if (exp_data[col_meta.channel].size() == 0) begin
                    note_error($sformatf("unexpected word on channel %0d", col_meta.channel));
                end else begin
                    want_word = exp_data[col_meta.channel].pop_front();
                    if (out_data !== want_word) begin
                        value_error("out_data", out_data, want_word);
                    end
                end
                if (out_eof) begin
                    spkt_open = 1'b0;
                    if (col_cnt != int'(col_meta.words)) begin
                        value_error("superpacket length", 32'(col_cnt), 32'(col_meta.words));
                    end
                    if (col_cnt > pack_pkg::SPKT_WORDS_MAX) begin
                        note_error("superpacket longer than the size limit");
                    end
                    if (exp_desc[col_meta.channel].size() == 0) begin
                        note_error("superpacket that the model never closed");
                    end else begin
                        want_desc = exp_desc[col_meta.channel].pop_front();
                        if (col_meta.words !== want_desc.words) begin
                            value_error("out_meta.words", 32'(col_meta.words),
                                        32'(want_desc.words));
                        end
                        if (col_meta.pkts !== want_desc.pkts) begin
                            value_error("out_meta.pkts", 32'(col_meta.pkts), 32'(want_desc.pkts));
                        end
                    end
                end
            end
        end else if (arst_n && (out_sof || out_eof)) begin
            note_error("out_sof or out_eof without out_vld");
        end
    end

    initial begin
        int len;
        int ch;
        int gap;
        int beats;
        int eof_t;
        int seen;
        int wait_n;
        int first;
        int mask;
        in_vld  = 1'b0;
        in_word = '0;
        for (int i = 0; i < pack_pkg::CHANNELS; i++) begin
            open_words[i] = 0;
            open_pkts[i]  = 0;
            last_beat[i]  = 0;
            mid[i]        = 1'b0;
        end
        @(posedge arst_n);
        if (out_vld !== 1'b0 || out_sof !== 1'b0 || out_eof !== 1'b0) begin
            note_error("output strobes not low after reset");
        end
        if (drop_cnt !== '0) begin
            value_error("drop_cnt", 32'(drop_cnt), 32'h0);
        end

        // two full packets on one channel then random lengths
        for (int i = 0; i < SIZE_PKTS; i++) begin
            len = (i < 2) ? 8 : 1 + pick_below(8);
            send_packet(2, len, len, 1);
        end
        end_test("size_close");

        send_packet(1, 3, 3, 1);
        eof_t  = last_beat[1];
        seen   = sof_cnt;
        wait_n = 0;
        while (sof_cnt == seen && wait_n < 2 * (pack_pkg::TIMEOUT_CLK + 40)) begin
            idle(1);
            wait_n++;
        end
        if (sof_cnt == seen) begin
            note_error("short packet never came out after the idle timeout");
        end else if (sof_cyc - eof_t > pack_pkg::TIMEOUT_CLK + 40) begin
            note_error($sformatf("idle close took %0d cycles after eof", sof_cyc - eof_t));
        end
        end_test("timeout_close");

        for (int i = 0; i < RAND_PKTS; i++) begin
            ch  = pick_below(4);
            len = 1 + pick_below(8);
            gap = 1 + pick_below(3);
            send_packet(ch, len, len, gap);
            if (pick_below(12) == 0) begin
                idle(GAP_TMO + pick_below(10));
            end
        end
        end_test("random_mixed");

        send_packet(0, 0, 1, 1);
        send_packet(1, 9, 9, 1);
        send_packet(2, 15, 15, 1);
        for (int i = 0; i < BAD_PKTS; i++) begin
            ch = pick_below(4);
            case (pick_below(3))
                0: begin
                    len   = 0;
                    beats = 1;
                end
                1: begin
                    len   = 9 + pick_below(7);
                    beats = len;
                end
                default: begin
                    len   = 1 + pick_below(8);
                    beats = len;
                end
            endcase
            send_packet(ch, len, beats, 1);
        end
        end_test("illegal_length");

        // lanes 1 to 3 close by timeout while lane 0 drains and refills
        first = served.size();
        send_packet(1, 1, 1, 0);
        send_packet(2, 1, 1, 0);
        send_packet(3, 1, 1, 0);
        for (int i = 0; i < 4; i++) begin
            send_packet(0, 8, 8, 0);
        end
        wait_n = 0;
        while (served.size() < first + 4 && wait_n < SETTLE) begin
            idle(1);
            wait_n++;
        end
        if (served.size() < first + 4) begin
            note_error("fewer than four superpackets came out of the fairness burst");
        end else begin
            mask = 0;
            for (int i = 0; i < 4; i++) begin
                mask = mask | (1 << served[first + i]);
            end
            if (mask != 15) begin
                note_error("a lane was served twice before every ready lane had a turn");
            end
        end
        end_test("fairness");

        $display("summary: %0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (MAX_BEATS * 4 + 2000) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", MAX_BEATS * 4 + 2000);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: src.f
design/pack_pkg.sv
design/pack_fifo.sv
design/pack_dispatch.sv
design/pack_lane.sv
design/pack_drain.sv
design/frame_packer.sv
sim/tb_clock.sv
sim/tb_frame_packer.sv

// File: run.sh
#!/bin/sh
# compile and run the frame packer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f src.f \
    --top-module tb_frame_packer -Mdir obj_dir

out=$(./obj_dir/Vtb_frame_packer || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^\*\*\* PASSED \*\*\*$'; then
    exit 0
fi
exit 1
